// ==== verilog/fpu_consts.svh ====
//////////////////////////////////////////////////////////////////////
// Single precision field layout and fixed encodings for the add/sub unit
// FPU_LATENCY must track the stage count in fpu_req_ack
//////////////////////////////////////////////////////////////////////

`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// Field widths
`define FP_EXP_W     8
`define FP_FRAC_W    23

// Exponent encoding
`define FP_BIAS      127
`define FP_EXP_MAX   8'hff   // Inf and NaN exponent

// Guard, round and sticky below the fraction LSB
`define FP_GRS_W     3

// Forced magnitudes, sign applied separately
`define FP_QNAN      31'h7fc00001
`define FP_INF       31'h7f800000

// Edges from req sampled high to ack raised
`define FPU_LATENCY  4

`endif

// ==== verilog/fpu_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types for the add/sub unit
// Widths come from fpu_consts.svh so the include path must reach verilog/
//////////////////////////////////////////////////////////////////////

`include "fpu_consts.svh"

package fpu_pkg;

	// IEEE 754 single precision word
	typedef struct packed {
		logic                  sign;
		logic [`FP_EXP_W-1:0]  exp;
		logic [`FP_FRAC_W-1:0] frac;
	} fp32_t;

	typedef enum logic {
		op_add = 1'b0,
		op_sub = 1'b1   // Flips sign of opb
	} fpu_op_e;

	// Per-operand class, denormals already folded into is_zero
	typedef struct packed {
		logic is_zero;
		logic is_inf;
		logic is_nan;
		logic is_snan;
	} fp_class_t;

	typedef struct packed {
		logic inf;
		logic qnan;
		logic snan;
		logic zero;
		logic overflow;
		logic ine;      // Inexact
	} fpu_flags_t;

endpackage

// ==== verilog/fp_classify.sv ====
//////////////////////////////////////////////////////////////////////
// Combinational operand decode, denormal inputs count as signed zero
// Forced result covers NaN operands, Inf minus Inf and Inf passthrough
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "fpu_consts.svh"

module fp_classify import fpu_pkg::*; (
	input  fp32_t      opa,
	input  fp32_t      opb,
	input  fpu_op_e    op,
	output fp_class_t  opa_class,
	output fp_class_t  opb_class,
	output logic       special,
	output fp32_t      special_result,
	output fpu_flags_t special_flags
);

	// Same decode for both operands
	function automatic fp_class_t decode(input fp32_t x);
		fp_class_t c;
		c.is_zero = (x.exp == '0);                            // Zero or denormal
		c.is_inf  = (x.exp == `FP_EXP_MAX) && (x.frac == '0);
		c.is_nan  = (x.exp == `FP_EXP_MAX) && (x.frac != '0);
		c.is_snan = c.is_nan && !x.frac[`FP_FRAC_W-1];         // Quiet bit clear
		return c;
	endfunction

	logic sign_b;      // Effective sign of opb
	logic any_nan;
	logic any_snan;
	logic inf_clash;   // Inf plus Inf of opposite sign

	assign opa_class = decode(opa);
	assign opb_class = decode(opb);

	assign sign_b    = opb.sign ^ (op == op_sub);
	assign any_nan   = opa_class.is_nan | opb_class.is_nan;
	assign any_snan  = opa_class.is_snan | opb_class.is_snan;
	assign inf_clash = opa_class.is_inf & opb_class.is_inf & (opa.sign ^ sign_b);

	// Any NaN or Inf operand overrides the datapath
	assign special = any_nan | opa_class.is_inf | opb_class.is_inf;

	//////////////////////////////////////////////////////////////////////
	// Forced word and flags
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		special_flags = '0;
		if (any_nan | inf_clash) begin
			special_result     = {1'b0, `FP_QNAN};   // Default qNaN, positive
			special_flags.qnan = 1'b1;
			special_flags.snan = any_snan;
		end else begin
			// Single Inf or two Infs agreeing in sign
			special_result    = {(opa_class.is_inf ? opa.sign : sign_b), `FP_INF};
			special_flags.inf = 1'b1;
		end
	end

endmodule

// ==== verilog/fp_pre_norm.sv ====
//////////////////////////////////////////////////////////////////////
// Stage 1 register, loads only on start and holds until the next start
// big_frac carries the larger magnitude, never smaller than small_frac
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "fpu_consts.svh"

module fp_pre_norm import fpu_pkg::*; (
	input  logic                             fpu_if,
	input  logic                             rst_n,
	input  logic                             start,
	input  fp32_t                            opa,
	input  fp32_t                            opb,
	input  fpu_op_e                          op,
	input  logic                             special,
	input  fp32_t                            special_result,
	input  fpu_flags_t                       special_flags,
	input  fp_class_t                        opa_class,
	input  fp_class_t                        opb_class,
	output logic [`FP_FRAC_W+`FP_GRS_W:0]    big_frac,
	output logic [`FP_FRAC_W+`FP_GRS_W:0]    small_frac,
	output logic [`FP_EXP_W-1:0]             exp_big,
	output logic                             eff_sub,
	output logic                             sign_out,
	output logic                             special_q,
	output fp32_t                            special_result_q,
	output fpu_flags_t                       special_flags_q
);

	localparam int MW = `FP_FRAC_W + 1 + `FP_GRS_W;   // Hidden + frac + GRS

	logic                  sign_b;
	logic [`FP_EXP_W-1:0]  exp_a, exp_b;
	logic [`FP_EXP_W-1:0]  exp_l, exp_s;
	logic [`FP_EXP_W-1:0]  diff;
	logic [`FP_FRAC_W:0]   mant_a, mant_b;
	logic [`FP_FRAC_W:0]   mant_l, mant_s;
	logic                  a_big;
	logic [4:0]            sh;
	logic [2*MW-1:0]       wide;      // Shifted value over bits shifted out
	logic [MW-1:0]         small_d;

	assign sign_b = opb.sign ^ (op == op_sub);

	// Zero class wipes exponent and mantissa, so denormals add nothing
	assign exp_a  = opa_class.is_zero ? '0 : opa.exp;
	assign exp_b  = opb_class.is_zero ? '0 : opb.exp;
	assign mant_a = opa_class.is_zero ? '0 : {1'b1, opa.frac};
	assign mant_b = opb_class.is_zero ? '0 : {1'b1, opb.frac};

	// Magnitude compare, exponent first
	assign a_big  = {exp_a, mant_a} >= {exp_b, mant_b};
	assign exp_l  = a_big ? exp_a : exp_b;
	assign exp_s  = a_big ? exp_b : exp_a;
	assign mant_l = a_big ? mant_a : mant_b;
	assign mant_s = a_big ? mant_b : mant_a;

	//////////////////////////////////////////////////////////////////////
	// Alignment
	//////////////////////////////////////////////////////////////////////

	assign diff = exp_l - exp_s;
	assign sh   = (diff > MW) ? 5'(MW) : diff[4:0];   // Past MW all bits are sticky
	assign wide = {mant_s, {`FP_GRS_W{1'b0}}, {MW{1'b0}}} >> sh;

	// Everything shifted out folds into the sticky bit
	assign small_d = {wide[2*MW-1:MW+1], wide[MW] | (|wide[MW-1:0])};

	always_ff @(posedge fpu_if or negedge rst_n) begin
		if (!rst_n)
			special_q <= 1'b0;
		else if (start)
			special_q <= special;
	end

	always_ff @(posedge fpu_if) begin
		if (start) begin
			big_frac         <= {mant_l, {`FP_GRS_W{1'b0}}};
			small_frac       <= small_d;
			exp_big          <= exp_l;
			eff_sub          <= opa.sign ^ sign_b;          // Signs differ
			sign_out         <= a_big ? opa.sign : sign_b;  // Larger magnitude wins
			special_result_q <= special_result;
			special_flags_q  <= special_flags;
		end
	end

	// Swap must leave a non-negative difference for stage 2
	assert property (@(posedge fpu_if) disable iff (!rst_n)
		$past(start) && eff_sub |-> small_frac <= big_frac)
		else $error("pre_norm: small_frac above big_frac on subtract");

endmodule

// ==== verilog/fp_post_norm.sv ====
//////////////////////////////////////////////////////////////////////
// Stage 2 register, round to nearest even only
// Results below the smallest normal flush to zero, no denormal output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "fpu_consts.svh"

module fp_post_norm import fpu_pkg::*; (
	input  logic                          fpu_if,
	input  logic                          rst_n,
	input  logic [`FP_FRAC_W+`FP_GRS_W:0] big_frac,
	input  logic [`FP_FRAC_W+`FP_GRS_W:0] small_frac,
	input  logic [`FP_EXP_W-1:0]          exp_big,
	input  logic                          eff_sub,
	input  logic                          sign_in,
	input  logic                          special,
	input  fp32_t                         special_result,
	input  fpu_flags_t                    special_flags,
	output fp32_t                         result,
	output fpu_flags_t                    flags
);

	localparam int MW = `FP_FRAC_W + 1 + `FP_GRS_W;
	localparam int EW = `FP_EXP_W + 2;   // Room for sign and exponent carry

	logic [MW:0]               sum;       // Extra bit for add carry
	logic [4:0]                lz;
	logic [MW-1:0]             norm;
	logic signed [EW-1:0]      exp_n;
	logic signed [EW-1:0]      exp_r;
	logic [`FP_FRAC_W+1:0]     rnd;       // Carry + hidden + frac
	logic                      round_up;
	logic                      inexact;
	logic                      res_zero, res_uf, res_ovf;
	fp32_t                     result_d;
	fpu_flags_t                flags_d;

	assign sum = eff_sub ? {1'b0, big_frac} - {1'b0, small_frac}
	                     : {1'b0, big_frac} + {1'b0, small_frac};

	// Leading zero count, highest set bit wins
	always_comb begin
		lz = '0;
		for (int i = 0; i < MW; i++)
			if (sum[i])
				lz = 5'(MW - 1 - i);
	end

	//////////////////////////////////////////////////////////////////////
	// Normalize
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (sum[MW]) begin
			norm  = {sum[MW:2], sum[1] | sum[0]};   // Right by one, keep sticky
			exp_n = EW'(exp_big) + 1;
		end else begin
			norm  = sum[MW-1:0] << lz;
			exp_n = EW'(exp_big) - EW'(lz);
		end
	end

	// Nearest even on guard, round, sticky and LSB
	assign inexact  = |norm[`FP_GRS_W-1:0];
	assign round_up = norm[2] & (norm[1] | norm[0] | norm[`FP_GRS_W]);
	assign rnd      = {1'b0, norm[MW-1:`FP_GRS_W]} + round_up;
	assign exp_r    = exp_n + EW'(rnd[`FP_FRAC_W+1]);   // Mantissa wrapped to 1.0

	assign res_zero = (sum == '0);                      // Exact, no rounding
	assign res_uf   = !res_zero && (exp_n <= 0);
	assign res_ovf  = !res_zero && !res_uf && (exp_r > 2 * `FP_BIAS);

	always_comb begin
		flags_d = '0;
		if (special) begin
			result_d = special_result;
			flags_d  = special_flags;
		end else if (res_zero) begin
			result_d     = {(sign_in & ~eff_sub), 31'b0};   // Cancellation gives +0
			flags_d.zero = 1'b1;
		end else if (res_uf) begin
			result_d     = {sign_in, 31'b0};   // Flush, keep sign
			flags_d.zero = 1'b1;
			flags_d.ine  = 1'b1;
		end else if (res_ovf) begin
			result_d         = {sign_in, `FP_INF};
			flags_d.overflow = 1'b1;
			flags_d.ine      = 1'b1;
			flags_d.inf      = 1'b1;
		end else begin
			result_d    = {sign_in, exp_r[`FP_EXP_W-1:0], rnd[`FP_FRAC_W-1:0]};
			flags_d.ine = inexact;
		end
	end

	always_ff @(posedge fpu_if or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
			flags  <= '0;
		end else begin
			result <= result_d;
			flags  <= flags_d;
		end
	end

	// Normalizer and rounder together keep a leading one
	assert property (@(posedge fpu_if) disable iff (!rst_n)
		!special && !res_zero |-> rnd[`FP_FRAC_W] || rnd[`FP_FRAC_W+1])
		else $error("post_norm: hidden bit lost before packing");

endmodule

// ==== verilog/fpu_req_ack.sv ====
//////////////////////////////////////////////////////////////////////
// Four-phase req/ack, one operation in flight
// Operands captured on the accepting edge, requester may change them after
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "fpu_consts.svh"

module fpu_req_ack import fpu_pkg::*; (
	input  logic    fpu_if,
	input  logic    rst_n,
	input  logic    req,
	input  fp32_t   opa,
	input  fp32_t   opb,
	input  fpu_op_e op,
	output fp32_t   opa_q,
	output fp32_t   opb_q,
	output fpu_op_e op_q,
	output logic    start,
	output logic    out_load,
	output logic    ack
);

	localparam int VW = `FPU_LATENCY - 2;   // Stages between start and output load

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,      // Pipeline running
		ST_DONE,      // Output register loaded, ack next edge
		ST_RELEASE    // Ack high until req seen low
	} state_e;

	state_e        state;
	logic [VW-1:0] vld;
	logic          accept;

	assign accept   = (state == ST_IDLE) && req;
	assign out_load = vld[VW-1];

	always_ff @(posedge fpu_if or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			start <= 1'b0;
			vld   <= '0;
			ack   <= 1'b0;
		end else begin
			start <= accept;                  // One cycle pulse
			vld   <= {vld[VW-2:0], start};
			case (state)
				ST_IDLE:    if (req) state <= ST_BUSY;
				ST_BUSY:    if (out_load) state <= ST_DONE;
				ST_DONE: begin
					ack   <= 1'b1;
					state <= ST_RELEASE;
				end
				ST_RELEASE: if (!req) begin
					ack   <= 1'b0;
					state <= ST_IDLE;
				end
				default:    state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge fpu_if) begin
		if (accept) begin
			opa_q <= opa;
			opb_q <= opb;
			op_q  <= op;
		end
	end

	// Requester side of the protocol
	assert property (@(posedge fpu_if) disable iff (!rst_n) $rose(ack) |-> $past(req))
		else $error("req_ack: ack raised without req");
	assert property (@(posedge fpu_if) disable iff (!rst_n) $rose(req) |-> !ack)
		else $error("req_ack: req raised while ack high");

endmodule

// ==== verilog/fpu_addsub.sv ====
//////////////////////////////////////////////////////////////////////
// Single precision add/sub, ack four edges after req is sampled
// result and flags stay valid from ack until the next result loads
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "fpu_consts.svh"

module fpu_addsub import fpu_pkg::*; (
	input  logic       fpu_if,
	input  logic       rst_n,
	input  logic       req,
	input  fp32_t      opa,
	input  fp32_t      opb,
	input  fpu_op_e    op,
	output logic       ack,
	output fp32_t      result,
	output fpu_flags_t flags
);

	localparam int MW = `FP_FRAC_W + 1 + `FP_GRS_W;

	// Captured operands
	fp32_t      opa_q, opb_q;
	fpu_op_e    op_q;
	logic       start;
	logic       out_load;

	// Classification, combinational
	fp_class_t  opa_class, opb_class;
	logic       special;
	fp32_t      special_result;
	fpu_flags_t special_flags;

	// Stage 1 outputs
	logic [MW-1:0]        big_frac, small_frac;
	logic [`FP_EXP_W-1:0] exp_big;
	logic                 eff_sub;
	logic                 sign_s1;
	logic                 special_s1;
	fp32_t                special_result_s1;
	fpu_flags_t           special_flags_s1;

	// Stage 2 outputs
	fp32_t      pn_result;
	fpu_flags_t pn_flags;

	fpu_req_ack u_req_ack (
		.fpu_if   (fpu_if),
		.rst_n    (rst_n),
		.req      (req),
		.opa      (opa),
		.opb      (opb),
		.op       (op),
		.opa_q    (opa_q),
		.opb_q    (opb_q),
		.op_q     (op_q),
		.start    (start),
		.out_load (out_load),
		.ack      (ack)
	);

	fp_classify u_classify (
		.opa            (opa_q),
		.opb            (opb_q),
		.op             (op_q),
		.opa_class      (opa_class),
		.opb_class      (opb_class),
		.special        (special),
		.special_result (special_result),
		.special_flags  (special_flags)
	);

	fp_pre_norm u_pre_norm (
		.fpu_if           (fpu_if),
		.rst_n            (rst_n),
		.start            (start),
		.opa              (opa_q),
		.opb              (opb_q),
		.op               (op_q),
		.special          (special),
		.special_result   (special_result),
		.special_flags    (special_flags),
		.opa_class        (opa_class),
		.opb_class        (opb_class),
		.big_frac         (big_frac),
		.small_frac       (small_frac),
		.exp_big          (exp_big),
		.eff_sub          (eff_sub),
		.sign_out         (sign_s1),
		.special_q        (special_s1),
		.special_result_q (special_result_s1),
		.special_flags_q  (special_flags_s1)
	);

	fp_post_norm u_post_norm (
		.fpu_if         (fpu_if),
		.rst_n          (rst_n),
		.big_frac       (big_frac),
		.small_frac     (small_frac),
		.exp_big        (exp_big),
		.eff_sub        (eff_sub),
		.sign_in        (sign_s1),
		.special        (special_s1),
		.special_result (special_result_s1),
		.special_flags  (special_flags_s1),
		.result         (pn_result),
		.flags          (pn_flags)
	);

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge fpu_if or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
			flags  <= '0;
		end else if (out_load) begin   // One edge ahead of ack
			result <= pn_result;
			flags  <= pn_flags;
		end
	end

endmodule

// ==== tests/fpu_checker.sv ====
//////////////////////////////////////////////////////////////////////
// Watches the req/ack pair and the outputs of the add/sub unit
// Expects the requester to hold the expected row until ack drops
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "fpu_consts.svh"

module fpu_checker import fpu_pkg::*; (
	input  logic       fpu_if,
	input  logic       rst_n,
	input  logic       req,
	input  logic       ack,
	input  fp32_t      result,
	input  fpu_flags_t flags,
	input  int         row_idx,      // Row being applied
	input  fp32_t      exp_result,
	input  fpu_flags_t exp_flags,
	output int         mismatches,
	output int         protocol_errors,
	output int         on_time      // Acks at exactly FPU_LATENCY
);

	localparam int STALL_LIMIT = `FPU_LATENCY + 2;   // Edges before a handshake counts as lost

	int         cyc;
	int         req_cyc;       // Edge that sampled req
	logic       waiting;       // Request accepted, no ack yet
	logic       drop_due;      // req seen low while ack high
	logic       ack_q;
	logic       check_reset;
	fp32_t      held_result;
	fpu_flags_t held_flags;

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			mismatches++;
			$display("mismatch at %0t: row %0d %s got %0h expected %0h",
				$time, row_idx, name, got, want);
		end
	endtask

	// First edge after ack rose, outputs loaded one edge before ack
	task automatic check_ack();
		if (!waiting) begin
			protocol_errors++;
			$display("ack raised near %0t with no request outstanding", $time);
		end else begin
			if (cyc - 1 - req_cyc == `FPU_LATENCY)
				on_time++;
			else
				compare_value("ack latency", cyc - 1 - req_cyc, `FPU_LATENCY);
			compare_value("result", result, exp_result);
			compare_value("flags.inf", flags.inf, exp_flags.inf);
			compare_value("flags.qnan", flags.qnan, exp_flags.qnan);
			compare_value("flags.snan", flags.snan, exp_flags.snan);
			compare_value("flags.zero", flags.zero, exp_flags.zero);
			compare_value("flags.overflow", flags.overflow, exp_flags.overflow);
			compare_value("flags.ine", flags.ine, exp_flags.ine);
		end
		waiting     = 1'b0;
		held_result = result;
		held_flags  = flags;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Edge monitor, reads values from before each edge
	//////////////////////////////////////////////////////////////////////

	always @(posedge fpu_if) begin
		if (!rst_n) begin
			cyc             = 0;
			mismatches      = 0;
			protocol_errors = 0;
			on_time         = 0;
			waiting         = 1'b0;
			drop_due        = 1'b0;
			ack_q           = 1'b0;
			check_reset     = 1'b1;
		end else begin
			cyc++;
			if (check_reset) begin   // Reset values
				compare_value("ack after reset", ack, 0);
				compare_value("result after reset", result, 0);
				compare_value("flags after reset", flags, 0);
				check_reset = 1'b0;
			end
			if (ack && !ack_q) begin
				check_ack();
			end else if (ack) begin   // Outputs must not move while ack is high
				compare_value("result while ack held", result, held_result);
				compare_value("flags while ack held", flags, held_flags);
			end
			if (drop_due && ack) begin
				protocol_errors++;
				$display("ack still high at %0t one edge after req was seen low", $time);
			end
			drop_due = ack && !req;
			if (!waiting && req && !ack) begin
				waiting = 1'b1;
				req_cyc = cyc;
			end else if (waiting && (cyc - req_cyc > STALL_LIMIT)) begin
				protocol_errors++;
				$display("handshake for row %0d not acknowledged within %0d cycles",
					row_idx, STALL_LIMIT);
				waiting = 1'b0;
			end
			ack_q = ack;
		end
	end

endmodule

// ==== tests/fpu_addsub_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Runs a fixed table through the four-phase handshake of fpu_addsub
// Idle gaps and req release delays come from an LCG with a fixed seed
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "fpu_consts.svh"

module fpu_addsub_tb import fpu_pkg::*; ();

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 4;
	localparam int DRIVE_DLY    = 1;                  // ns after the rising edge
	localparam int ROW_CYCLES   = `FPU_LATENCY + 10;  // Worst row with gaps and hold

	// Flag words, bits are inf qnan snan zero overflow ine
	localparam fpu_flags_t FL_NONE  = 6'b000000;
	localparam fpu_flags_t FL_INE   = 6'b000001;
	localparam fpu_flags_t FL_ZERO  = 6'b000100;
	localparam fpu_flags_t FL_UFLOW = 6'b000101;   // Flushed
	localparam fpu_flags_t FL_OVF   = 6'b100011;
	localparam fpu_flags_t FL_INF   = 6'b100000;
	localparam fpu_flags_t FL_QNAN  = 6'b010000;
	localparam fpu_flags_t FL_SNAN  = 6'b011000;

	typedef struct packed {
		fp32_t      opa;
		fp32_t      opb;
		fpu_op_e    op;
		fp32_t      exp_result;
		fpu_flags_t exp_flags;
	} row_t;

	logic       fpu_if;
	logic       rst_n;
	logic       req;
	fp32_t      opa;
	fp32_t      opb;
	fpu_op_e    op;
	logic       ack;
	fp32_t      result;
	fpu_flags_t flags;

	row_t        rows[$];
	bit          table_ready;
	int          row_idx;
	fp32_t       exp_result;
	fpu_flags_t  exp_flags;
	logic [31:0] rand_state;
	int          n_mismatch;
	int          n_protocol;
	int          n_on_time;

	fpu_addsub dut (
		.fpu_if (fpu_if),
		.rst_n  (rst_n),
		.req    (req),
		.opa    (opa),
		.opb    (opb),
		.op     (op),
		.ack    (ack),
		.result (result),
		.flags  (flags)
	);

	fpu_checker chk (
		.fpu_if          (fpu_if),
		.rst_n           (rst_n),
		.req             (req),
		.ack             (ack),
		.result          (result),
		.flags           (flags),
		.row_idx         (row_idx),
		.exp_result      (exp_result),
		.exp_flags       (exp_flags),
		.mismatches      (n_mismatch),
		.protocol_errors (n_protocol),
		.on_time         (n_on_time)
	);

	initial begin
		fpu_if = 1'b0;
		forever #(CLK_PERIOD / 2) fpu_if = ~fpu_if;
	end

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	task automatic next_cycle();
		@(posedge fpu_if);
		#DRIVE_DLY;
	endtask

	task automatic add_row(input fp32_t a, input fp32_t b, input fpu_op_e o,
			input fp32_t r, input fpu_flags_t f);
		rows.push_back(row_t'{a, b, o, r, f});
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus table, expected values worked out by hand
	//////////////////////////////////////////////////////////////////////

	task automatic fill_table();
		add_row(32'h3f800000, 32'h40000000, op_add, 32'h40400000, FL_NONE);  // 1 + 2
		add_row(32'h40400000, 32'h3f800000, op_sub, 32'h40000000, FL_NONE);  // 3 - 1
		add_row(32'h3fc00000, 32'hbf000000, op_add, 32'h3f800000, FL_NONE);  // 1.5 + -0.5
		add_row(32'h3fc00000, 32'h3fc00000, op_add, 32'h40400000, FL_NONE);  // Add carry
		add_row(32'h3f800000, 32'h3f400000, op_sub, 32'h3e800000, FL_NONE);  // Left shift 2
		add_row(32'h3f800000, 32'h40000000, op_sub, 32'hbf800000, FL_NONE);  // Negative
		add_row(32'h3f800000, 32'h33800000, op_add, 32'h3f800000, FL_INE);   // Tie, stays even
		add_row(32'h3f800001, 32'h33800000, op_add, 32'h3f800002, FL_INE);   // Tie, up to even
		add_row(32'h3f800000, 32'h33c00000, op_add, 32'h3f800001, FL_INE);   // Above half
		add_row(32'h3fffffff, 32'h33800000, op_add, 32'h40000000, FL_INE);   // Round carry
		add_row(32'h3f800001, 32'h3f800000, op_add, 32'h40000000, FL_INE);   // Carry then tie
		add_row(32'h3f800000, 32'h33000000, op_sub, 32'h3f800000, FL_INE);   // Borrow tie
		add_row(32'h3f800000, 32'h3f800000, op_sub, 32'h00000000, FL_ZERO);  // Cancel
		add_row(32'hbf800000, 32'h3f800000, op_add, 32'h00000000, FL_ZERO);  // Cancel, +0
		add_row(32'h3f800000, 32'h00000001, op_add, 32'h3f800000, FL_NONE);  // Denormal is 0
		add_row(32'h80000000, 32'h80000001, op_add, 32'h80000000, FL_ZERO);  // -0 + -0
		add_row(32'h00c00000, 32'h00800000, op_sub, 32'h00000000, FL_UFLOW); // Flush
		add_row(32'h80c00000, 32'h80800000, op_sub, 32'h80000000, FL_UFLOW); // Flush, negative
		add_row(32'h7f7fffff, 32'h7f7fffff, op_add, 32'h7f800000, FL_OVF);   // Max + max
		add_row(32'hff7fffff, 32'hff7fffff, op_add, 32'hff800000, FL_OVF);
		add_row(32'h7f7fffff, 32'h73000000, op_add, 32'h7f800000, FL_OVF);   // Rounds past max
		add_row(32'h7f800000, 32'h3f800000, op_add, 32'h7f800000, FL_INF);
		add_row(32'h3f800000, 32'h7f800000, op_sub, 32'hff800000, FL_INF);   // 1 - inf
		add_row(32'hff800000, 32'hff800000, op_add, 32'hff800000, FL_INF);
		add_row(32'h7fc00000, 32'h3f800000, op_add, 32'h7fc00001, FL_QNAN);
		add_row(32'h3f800000, 32'h7f800001, op_add, 32'h7fc00001, FL_SNAN);
		add_row(32'hffc00000, 32'h3f800000, op_sub, 32'h7fc00001, FL_QNAN);  // Sign dropped
		add_row(32'h7f800000, 32'h7f800000, op_sub, 32'h7fc00001, FL_QNAN);  // inf - inf
		add_row(32'hff800000, 32'h7f800000, op_add, 32'h7fc00001, FL_QNAN);
	endtask

	// One full four-phase cycle
	task automatic run_row(input int i);
		int idle;
		int hold;
		idle = (next_rand() >> 16) & 3;
		repeat (idle) next_cycle();
		row_idx    = i;
		exp_result = rows[i].exp_result;
		exp_flags  = rows[i].exp_flags;
		opa        = rows[i].opa;
		opb        = rows[i].opb;
		op         = rows[i].op;
		req        = 1'b1;
		next_cycle();                        // Edge that captures the operands
		opa = next_rand();                   // Operands free after capture
		opb = next_rand();
		op  = (next_rand() > 32'h7fffffff) ? op_sub : op_add;
		while (!ack)
			next_cycle();
		hold = (next_rand() >> 16) & 3;
		repeat (hold) next_cycle();          // Back-pressure, ack stays high
		req = 1'b0;
		while (ack)
			next_cycle();
	endtask

	initial begin
		rst_n      = 1'b0;
		req        = 1'b0;
		opa        = '0;
		opb        = '0;
		op         = op_add;
		row_idx    = 0;
		exp_result = '0;
		exp_flags  = '0;
		rand_state = 32'h1cf6;
		fill_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge fpu_if);
		#DRIVE_DLY rst_n = 1'b1;
		for (int i = 0; i < rows.size(); i++)
			run_row(i);
		repeat (2) next_cycle();
		$display("checks done: %0d mismatches, %0d protocol errors, %0d of %0d acks on time",
			n_mismatch, n_protocol, n_on_time, rows.size());
		if (n_mismatch == 0 && n_protocol == 0 && n_on_time == rows.size())
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Run limit from the table length
	initial begin
		int cycles;
		int limit;
		wait (table_ready);
		limit  = rows.size() * ROW_CYCLES + RESET_CYCLES;
		cycles = 0;
		while (cycles < limit) begin
			@(posedge fpu_if);
			cycles++;
		end
		$display("timeout: run stopped after %0d cycles with row %0d unfinished",
			cycles, row_idx);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/fpu_pkg.sv
verilog/fp_classify.sv
verilog/fp_pre_norm.sv
verilog/fp_post_norm.sv
verilog/fpu_req_ack.sv
verilog/fpu_addsub.sv
tests/fpu_checker.sv
tests/fpu_addsub_tb.sv
